// File: rtl/mmio_pkg.sv
`default_nettype none

package mmio_pkg;

    //////////////////////////////////////////////////
    // widths with a meaning
    //////////////////////////////////////////////////

    typedef logic [31:0] word_t;
    typedef logic [29:0] word_addr_t;
    typedef logic [3:0]  byte_en_t;
    typedef logic [7:0]  char_t;
    typedef logic [14:0] vmem_addr_t;
    typedef logic [63:0] trace_entry_t;

    // anything not listed below lands in the data cache
    typedef enum logic [2:0] {
        REGION_CACHE,
        REGION_VMEM,
        REGION_DEBUG,
        REGION_KBD,
        REGION_LOADER
    } region_e;

    typedef enum logic [1:0] {
        VMEM_IDLE,
        VMEM_WRITE,
        VMEM_RELEASE
    } vmem_state_e;

    //////////////////////////////////////////////////
    // request bundles
    //////////////////////////////////////////////////

    typedef struct packed {
        logic       read;
        logic       write;
        word_addr_t addr;
        word_t      wdata;
        byte_en_t   byte_en;
    } dmem_req_t;

    // byte_en already lane reversed for the target
    typedef struct packed {
        logic     read;
        logic     write;
        byte_en_t byte_en;
    } target_req_t;

    typedef struct packed {
        logic       en;
        vmem_addr_t addr;
        char_t      char;
    } vmem_wr_t;

    // word address bits 29..26
    localparam logic [3:0] REGION_CODE_VMEM   = 4'hC;
    localparam logic [3:0] REGION_CODE_DEBUG  = 4'hD;
    localparam logic [3:0] REGION_CODE_KBD    = 4'hE;
    localparam logic [3:0] REGION_CODE_LOADER = 4'hF;

    // word address bits 25..18 inside the debug region
    localparam logic [7:0] TRAP_TAG = 8'hDD;

    localparam logic [25:0] DBG_START_ADDR = 26'h3000001;
    localparam logic [25:0] DBG_END_ADDR   = 26'h3000002;

endpackage

`default_nettype wire

// File: rtl/mmio_region_decode.sv
`timescale 1ns/1ps
`default_nettype none

module mmio_region_decode (
    input  mmio_pkg::dmem_req_t   dmem,
    input  mmio_pkg::word_addr_t  instr_addr,
    output mmio_pkg::region_e     region,
    output logic                  trap_access,
    output logic                  dbg_sel_start,
    output logic                  dbg_sel_end,
    output logic [5:0]            dbg_index,
    output logic                  dbg_half,
    output logic                  vmem_access,
    output logic                  kb_read,
    output mmio_pkg::target_req_t dc_req,
    output mmio_pkg::target_req_t loader_req,
    output logic                  loader_fetch
);
    import mmio_pkg::*;

    byte_en_t rev_byte_en;
    logic     in_debug;

    // data address classification
    always_comb begin
        case (dmem.addr[29:26])
            REGION_CODE_VMEM:   region = REGION_VMEM;
            REGION_CODE_DEBUG:  region = REGION_DEBUG;
            REGION_CODE_KBD:    region = REGION_KBD;
            REGION_CODE_LOADER: region = REGION_LOADER;
            // flash window folds in here too
            default:            region = REGION_CACHE;
        endcase
    end

    assign in_debug = (region == REGION_DEBUG);

    // tag DD hangs the core for as long as the access is held
    assign trap_access = in_debug && (dmem.addr[25:18] == TRAP_TAG)
                         && (dmem.read || dmem.write);

    assign dbg_sel_start = in_debug && (dmem.addr[25:0] == DBG_START_ADDR);
    assign dbg_sel_end   = in_debug && (dmem.addr[25:0] == DBG_END_ADDR);
    // entry number, then low or high half
    assign dbg_index     = dmem.addr[6:1];
    assign dbg_half      = dmem.addr[0];

    assign vmem_access = (region == REGION_VMEM) && dmem.write;
    assign kb_read     = (region == REGION_KBD) && dmem.read;

    // core lane order is opposite to cache and loader
    always_comb begin
        case (dmem.byte_en)
            4'b0001: rev_byte_en = 4'b1000;
            4'b0010: rev_byte_en = 4'b0100;
            4'b0100: rev_byte_en = 4'b0010;
            4'b1000: rev_byte_en = 4'b0001;
            4'b0011: rev_byte_en = 4'b1100;
            4'b1100: rev_byte_en = 4'b0011;
            default: rev_byte_en = 4'b1111;
        endcase
    end

    always_comb begin
        dc_req.read     = (region == REGION_CACHE) && dmem.read;
        dc_req.write    = (region == REGION_CACHE) && dmem.write;
        dc_req.byte_en  = dc_req.write ? rev_byte_en : 4'b0000;

        loader_req.read    = (region == REGION_LOADER) && dmem.read;
        loader_req.write   = (region == REGION_LOADER) && dmem.write;
        loader_req.byte_en = loader_req.write ? rev_byte_en : 4'b0000;
    end

    // fetches from the loader window bypass the icache
    assign loader_fetch = (instr_addr[29:26] == REGION_CODE_LOADER);

endmodule

`default_nettype wire

// File: rtl/vmem_write_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module vmem_write_ctrl #(
    parameter int VMEM_WAIT_CYCLES = 5
) (
    input  logic                clk_pipeline,
    input  logic                rst,
    input  logic                vmem_access,
    input  mmio_pkg::dmem_req_t dmem,
    output mmio_pkg::vmem_wr_t  vmem_wr,
    output logic                vmem_stall
);
    import mmio_pkg::*;

    localparam int               CNT_W    = $clog2(VMEM_WAIT_CYCLES + 3);
    localparam logic [CNT_W-1:0] WR_LAST  = CNT_W'(VMEM_WAIT_CYCLES);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(VMEM_WAIT_CYCLES + 2);

    vmem_state_e      state;
    logic [CNT_W-1:0] cnt;
    logic             wr_en;
    logic [1:0]       lane;
    char_t            wr_char;

    always_ff @(posedge clk_pipeline) begin
        if (!rst) begin
            state <= VMEM_IDLE;
            cnt   <= '0;
            wr_en <= 1'b0;
        end else begin
            case (state)
                VMEM_IDLE: begin
                    if (vmem_access) begin
                        state <= VMEM_WRITE;
                        cnt   <= CNT_W'(1);
                        wr_en <= 1'b1;
                    end
                end
                VMEM_WRITE: begin
                    if (!vmem_access) begin
                        // core dropped the request early
                        state <= VMEM_IDLE;
                        cnt   <= '0;
                        wr_en <= 1'b0;
                    end else if (cnt == CNT_LAST) begin
                        state <= VMEM_RELEASE;
                        wr_en <= 1'b0;
                    end else begin
                        cnt   <= cnt + CNT_W'(1);
                        wr_en <= (cnt <= WR_LAST);
                    end
                end
                default: begin
                    // hold here until the core moves on
                    if (!vmem_access) begin
                        state <= VMEM_IDLE;
                        cnt   <= '0;
                    end
                end
            endcase
        end
    end

    // byte within the word, from the core's lane
    always_comb begin
        case (dmem.byte_en)
            4'b1000: begin
                lane    = 2'd0;
                wr_char = dmem.wdata[7:0];
            end
            4'b0100: begin
                lane    = 2'd1;
                wr_char = dmem.wdata[15:8];
            end
            4'b0010: begin
                lane    = 2'd2;
                wr_char = dmem.wdata[23:16];
            end
            default: begin
                lane    = 2'd3;
                wr_char = dmem.wdata[31:24];
            end
        endcase
    end

    always_comb begin
        vmem_wr.en   = wr_en;
        vmem_wr.addr = {dmem.addr[12:0], lane};
        vmem_wr.char = wr_char;
    end

    assign vmem_stall = vmem_access && (state != VMEM_RELEASE);

endmodule

`default_nettype wire

// File: rtl/trace_queue.sv
`timescale 1ns/1ps
`default_nettype none

module trace_queue #(
    parameter int TRACE_DEPTH = 64
) (
    input  logic                   clk_pipeline,
    input  logic                   rst,
    input  logic                   cache_stall,
    input  mmio_pkg::trace_entry_t trace_in,
    input  logic [5:0]             dbg_index,
    input  logic                   dbg_half,
    output logic [5:0]             que_start,
    output logic [5:0]             que_end,
    output mmio_pkg::word_t        entry_word
);
    import mmio_pkg::*;

    localparam logic [5:0] LAST_SLOT = 6'(TRACE_DEPTH - 1);

    trace_entry_t queue [TRACE_DEPTH];
    trace_entry_t entry;
    logic [5:0]   end_next;
    // high while inside a stall run
    logic         in_run;

    assign end_next = (que_end == LAST_SLOT) ? 6'd0 : que_end + 6'd1;

    //////////////////////////////////////////////////
    // pointers
    //////////////////////////////////////////////////

    always_ff @(posedge clk_pipeline) begin
        if (!rst) begin
            que_start <= 6'd0;
            que_end   <= 6'd0;
            in_run    <= 1'b0;
        end else if (cache_stall) begin
            // mark where this run begins
            if (!in_run) begin
                que_start <= que_end;
            end
            in_run  <= 1'b1;
            que_end <= end_next;
        end else begin
            in_run <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // record storage
    //////////////////////////////////////////////////

    // oldest entries get overwritten on wrap
    always_ff @(posedge clk_pipeline) begin
        if (cache_stall) begin
            queue[que_end] <= trace_in;
        end
    end

    assign entry      = queue[dbg_index];
    assign entry_word = dbg_half ? entry[63:32] : entry[31:0];

endmodule

`default_nettype wire

// File: rtl/mmio_read_mux.sv
`timescale 1ns/1ps
`default_nettype none

module mmio_read_mux (
    input  mmio_pkg::region_e region,
    input  logic              trap_access,
    input  logic              dbg_sel_start,
    input  logic              dbg_sel_end,
    input  logic              loader_fetch,
    input  logic [5:0]        que_start,
    input  logic [5:0]        que_end,
    input  mmio_pkg::word_t   entry_word,
    input  mmio_pkg::word_t   dc_rdata,
    input  mmio_pkg::word_t   ic_rdata,
    input  mmio_pkg::word_t   loader_rdata,
    input  mmio_pkg::word_t   loader_instr,
    input  mmio_pkg::char_t   kb_keycode,
    input  logic              kb_read,
    input  logic              kb_ready,
    input  logic              cache_stall,
    input  logic              vmem_stall,
    output mmio_pkg::word_t   dmem_rdata,
    output mmio_pkg::word_t   instr_rdata,
    output logic              mem_stall
);
    import mmio_pkg::*;

    logic kb_stall;

    // data read select
    always_comb begin
        case (region)
            REGION_CACHE:  dmem_rdata = dc_rdata;
            REGION_LOADER: dmem_rdata = loader_rdata;
            REGION_KBD:    dmem_rdata = {24'd0, kb_keycode};
            REGION_DEBUG: begin
                if (trap_access) begin
                    dmem_rdata = '0;
                end else if (dbg_sel_start) begin
                    dmem_rdata = {26'd0, que_start};
                end else if (dbg_sel_end) begin
                    dmem_rdata = {26'd0, que_end};
                end else begin
                    dmem_rdata = entry_word;
                end
            end
            // video memory is write only
            default:       dmem_rdata = '0;
        endcase
    end

    assign instr_rdata = loader_fetch ? loader_instr : ic_rdata;

    // no scancode waiting yet
    assign kb_stall = kb_read && !kb_ready;

    assign mem_stall = cache_stall || vmem_stall || trap_access || kb_stall;

endmodule

`default_nettype wire

// File: rtl/cpu_mmio_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_mmio_bridge #(
    parameter int VMEM_WAIT_CYCLES = 5,
    parameter int TRACE_DEPTH      = 64
) (
    input  logic                   clk_pipeline,
    input  logic                   rst,
    // core side
    input  mmio_pkg::dmem_req_t    dmem,
    input  mmio_pkg::word_addr_t   instr_addr,
    // data and instruction cache
    output mmio_pkg::target_req_t  dc_req,
    input  mmio_pkg::word_t        dc_rdata,
    input  mmio_pkg::word_t        ic_rdata,
    input  logic                   cache_stall,
    input  mmio_pkg::trace_entry_t trace_in,
    // loader RAM
    output mmio_pkg::target_req_t  loader_req,
    input  mmio_pkg::word_t        loader_rdata,
    input  mmio_pkg::word_t        loader_instr,
    output logic                   loader_fetch,
    // text video memory
    output mmio_pkg::vmem_wr_t     vmem_wr,
    // keyboard
    output logic                   kb_read,
    input  logic                   kb_ready,
    input  mmio_pkg::char_t        kb_keycode,
    // back to the core
    output mmio_pkg::word_t        dmem_rdata,
    output mmio_pkg::word_t        instr_rdata,
    output logic                   mem_stall
);
    import mmio_pkg::*;

    region_e    region;
    logic       trap_access;
    logic       dbg_sel_start;
    logic       dbg_sel_end;
    logic [5:0] dbg_index;
    logic       dbg_half;
    logic       vmem_access;
    logic       vmem_stall;
    logic [5:0] que_start;
    logic [5:0] que_end;
    word_t      entry_word;

    //////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////

    mmio_region_decode u_decode (
        .dmem          (dmem),
        .instr_addr    (instr_addr),
        .region        (region),
        .trap_access   (trap_access),
        .dbg_sel_start (dbg_sel_start),
        .dbg_sel_end   (dbg_sel_end),
        .dbg_index     (dbg_index),
        .dbg_half      (dbg_half),
        .vmem_access   (vmem_access),
        .kb_read       (kb_read),
        .dc_req        (dc_req),
        .loader_req    (loader_req),
        .loader_fetch  (loader_fetch)
    );

    //////////////////////////////////////////////////
    // execute
    //////////////////////////////////////////////////

    vmem_write_ctrl #(
        .VMEM_WAIT_CYCLES (VMEM_WAIT_CYCLES)
    ) u_vmem (
        .clk_pipeline (clk_pipeline),
        .rst          (rst),
        .vmem_access  (vmem_access),
        .dmem         (dmem),
        .vmem_wr      (vmem_wr),
        .vmem_stall   (vmem_stall)
    );

    trace_queue #(
        .TRACE_DEPTH (TRACE_DEPTH)
    ) u_trace (
        .clk_pipeline (clk_pipeline),
        .rst          (rst),
        .cache_stall  (cache_stall),
        .trace_in     (trace_in),
        .dbg_index    (dbg_index),
        .dbg_half     (dbg_half),
        .que_start    (que_start),
        .que_end      (que_end),
        .entry_word   (entry_word)
    );

    //////////////////////////////////////////////////
    // result
    //////////////////////////////////////////////////

    mmio_read_mux u_mux (
        .region        (region),
        .trap_access   (trap_access),
        .dbg_sel_start (dbg_sel_start),
        .dbg_sel_end   (dbg_sel_end),
        .loader_fetch  (loader_fetch),
        .que_start     (que_start),
        .que_end       (que_end),
        .entry_word    (entry_word),
        .dc_rdata      (dc_rdata),
        .ic_rdata      (ic_rdata),
        .loader_rdata  (loader_rdata),
        .loader_instr  (loader_instr),
        .kb_keycode    (kb_keycode),
        .kb_read       (kb_read),
        .kb_ready      (kb_ready),
        .cache_stall   (cache_stall),
        .vmem_stall    (vmem_stall),
        .dmem_rdata    (dmem_rdata),
        .instr_rdata   (instr_rdata),
        .mem_stall     (mem_stall)
    );

endmodule

`default_nettype wire

// File: verification/cpu_mmio_bridge_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_mmio_bridge_tb;
    import mmio_pkg::*;

    localparam int VMEM_WAIT_CYCLES = 5;
    localparam int TRACE_DEPTH      = 64;

    // one table row, stimulus first and then the expected responses
    typedef struct packed {
        dmem_req_t    dmem;
        word_addr_t   instr_addr;
        word_t        dc_rdata;
        word_t        ic_rdata;
        word_t        loader_rdata;
        word_t        loader_instr;
        logic         kb_ready;
        char_t        kb_keycode;
        logic         cache_stall;
        trace_entry_t trace_in;
        word_t        exp_dmem_rdata;
        word_t        exp_instr_rdata;
        logic         exp_mem_stall;
        target_req_t  exp_dc_req;
        target_req_t  exp_loader_req;
        logic         exp_loader_fetch;
        logic         exp_kb_read;
        vmem_wr_t     exp_vmem_wr;
    } row_t;

    logic         clk_pipeline;
    logic         rst;
    dmem_req_t    dmem;
    word_addr_t   instr_addr;
    target_req_t  dc_req;
    word_t        dc_rdata;
    word_t        ic_rdata;
    logic         cache_stall;
    trace_entry_t trace_in;
    target_req_t  loader_req;
    word_t        loader_rdata;
    word_t        loader_instr;
    logic         loader_fetch;
    vmem_wr_t     vmem_wr;
    logic         kb_read;
    logic         kb_ready;
    char_t        kb_keycode;
    word_t        dmem_rdata;
    word_t        instr_rdata;
    logic         mem_stall;

    row_t        rows[$];
    row_t        cur;
    logic [31:0] lcg_state;
    // end pointer as the trace queue should hold it after the rows built so far
    logic [5:0]  model_end;
    bit          table_built = 1'b0;

    // core enable and the target enable it must turn into
    byte_en_t lane_in  [8] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                               4'b0011, 4'b1100, 4'b0110, 4'b1111};
    byte_en_t lane_out [8] = '{4'b1000, 4'b0100, 4'b0010, 4'b0001,
                               4'b1100, 4'b0011, 4'b1111, 4'b1111};

    cpu_mmio_bridge #(
        .VMEM_WAIT_CYCLES (VMEM_WAIT_CYCLES),
        .TRACE_DEPTH      (TRACE_DEPTH)
    ) dut (
        .clk_pipeline (clk_pipeline),
        .rst          (rst),
        .dmem         (dmem),
        .instr_addr   (instr_addr),
        .dc_req       (dc_req),
        .dc_rdata     (dc_rdata),
        .ic_rdata     (ic_rdata),
        .cache_stall  (cache_stall),
        .trace_in     (trace_in),
        .loader_req   (loader_req),
        .loader_rdata (loader_rdata),
        .loader_instr (loader_instr),
        .loader_fetch (loader_fetch),
        .vmem_wr      (vmem_wr),
        .kb_read      (kb_read),
        .kb_ready     (kb_ready),
        .kb_keycode   (kb_keycode),
        .dmem_rdata   (dmem_rdata),
        .instr_rdata  (instr_rdata),
        .mem_stall    (mem_stall)
    );

    initial clk_pipeline = 1'b0;
    always #4 clk_pipeline = ~clk_pipeline;

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    function automatic word_t next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input int n,
                               input logic [63:0] actual, input logic [63:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t: row %0d %s is %h, expected %h",
                     $time, n, name, actual, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // idle core, random target data, nothing stalled
    task automatic start_row();
        cur = '0;
        cur.dmem.addr       = {4'h1, 26'(next_rand())};
        cur.dmem.wdata      = next_rand();
        cur.dmem.byte_en    = 4'(next_rand());
        cur.instr_addr      = {4'h1, 26'(next_rand())};
        cur.dc_rdata        = next_rand();
        cur.ic_rdata        = next_rand();
        cur.loader_rdata    = next_rand();
        cur.loader_instr    = next_rand();
        cur.kb_ready        = 1'b1;
        cur.kb_keycode      = 8'(next_rand());
        cur.trace_in[63:32] = next_rand();
        cur.trace_in[31:0]  = next_rand();
        cur.exp_dmem_rdata  = cur.dc_rdata;
        cur.exp_instr_rdata = cur.ic_rdata;
    endtask

    task automatic push_row();
        if (cur.cache_stall) begin
            model_end = model_end + 6'd1;
        end
        rows.push_back(cur);
    endtask

    //////////////////////////////////////////////////
    // table building
    //////////////////////////////////////////////////

    task automatic add_region_reads();
        // cache region, then the flash window that folds into it
        start_row();
        cur.dmem.read   = 1'b1;
        cur.dmem.addr   = {4'h3, 26'(next_rand())};
        cur.exp_dc_req  = {1'b1, 1'b0, 4'b0000};
        push_row();
        start_row();
        cur.dmem.read   = 1'b1;
        cur.dmem.addr   = {4'hB, 26'(next_rand())};
        cur.exp_dc_req  = {1'b1, 1'b0, 4'b0000};
        push_row();
        start_row();
        cur.dmem.read       = 1'b1;
        cur.dmem.addr       = {4'hF, 26'(next_rand())};
        cur.exp_dmem_rdata  = cur.loader_rdata;
        cur.exp_loader_req  = {1'b1, 1'b0, 4'b0000};
        push_row();
        start_row();
        cur.dmem.read      = 1'b1;
        cur.dmem.addr      = {4'hE, 26'(next_rand())};
        cur.exp_dmem_rdata = {24'd0, cur.kb_keycode};
        cur.exp_kb_read    = 1'b1;
        push_row();
        // video memory reads back nothing
        start_row();
        cur.dmem.read      = 1'b1;
        cur.dmem.addr      = {4'hC, 26'(next_rand())};
        cur.exp_dmem_rdata = '0;
        push_row();
    endtask

    task automatic add_lane_writes();
        for (int i = 0; i < 8; i++) begin
            start_row();
            cur.dmem.write   = 1'b1;
            cur.dmem.addr    = {4'h2, 26'(next_rand())};
            cur.dmem.byte_en = lane_in[i];
            cur.exp_dc_req   = {1'b0, 1'b1, lane_out[i]};
            push_row();
            start_row();
            cur.dmem.write     = 1'b1;
            cur.dmem.addr      = {4'hF, 26'(next_rand())};
            cur.dmem.byte_en   = lane_in[i];
            cur.exp_dmem_rdata = cur.loader_rdata;
            cur.exp_loader_req = {1'b0, 1'b1, lane_out[i]};
            push_row();
        end
    endtask

    task automatic add_fetches();
        start_row();
        cur.instr_addr       = {4'hF, 26'(next_rand())};
        cur.exp_instr_rdata  = cur.loader_instr;
        cur.exp_loader_fetch = 1'b1;
        push_row();
        start_row();
        cur.instr_addr = {4'hE, 26'(next_rand())};
        push_row();
    endtask

    // held write, then one idle row so the FSM can return to idle
    task automatic add_video_write(input byte_en_t be, input logic [1:0] lane);
        word_addr_t vaddr;
        word_t      vdata;
        vaddr = {4'hC, 26'(next_rand())};
        vdata = next_rand();
        for (int c = 1; c <= VMEM_WAIT_CYCLES + 4; c++) begin
            start_row();
            cur.dmem.write          = 1'b1;
            cur.dmem.addr           = vaddr;
            cur.dmem.wdata          = vdata;
            cur.dmem.byte_en        = be;
            cur.exp_dmem_rdata      = '0;
            cur.exp_mem_stall       = (c <= VMEM_WAIT_CYCLES + 3);
            cur.exp_vmem_wr.en      = (c >= 2) && (c <= VMEM_WAIT_CYCLES + 2);
            cur.exp_vmem_wr.addr    = {vaddr[12:0], lane};
            cur.exp_vmem_wr.char    = 8'(vdata >> (8 * lane));
            push_row();
        end
        start_row();
        push_row();
    endtask

    task automatic add_trace_run();
        logic [5:0]   old_end;
        logic [5:0]   slot;
        trace_entry_t recs [5];
        // a quiet row closes any earlier stall run
        start_row();
        push_row();
        old_end = model_end;
        for (int i = 0; i < 5; i++) begin
            start_row();
            cur.cache_stall   = 1'b1;
            cur.exp_mem_stall = 1'b1;
            recs[i]           = cur.trace_in;
            push_row();
        end
        start_row();
        cur.dmem.read      = 1'b1;
        cur.dmem.addr      = {4'hD, 26'h3000001};
        cur.exp_dmem_rdata = {26'd0, old_end};
        push_row();
        start_row();
        cur.dmem.read      = 1'b1;
        cur.dmem.addr      = {4'hD, 26'h3000002};
        cur.exp_dmem_rdata = {26'd0, 6'(old_end + 6'd5)};
        push_row();
        for (int i = 0; i < 5; i++) begin
            for (int h = 0; h < 2; h++) begin
                slot = old_end + 6'(i);
                start_row();
                cur.dmem.read      = 1'b1;
                cur.dmem.addr      = {4'hD, 19'd0, slot, 1'(h)};
                cur.exp_dmem_rdata = (h == 1) ? recs[i][63:32] : recs[i][31:0];
                push_row();
            end
        end
    endtask

    task automatic add_stall_sources();
        // trap read held for three cycles, then a trap write
        // each one lands on a trace slot that already holds a record
        for (int i = 0; i < 4; i++) begin
            start_row();
            cur.dmem.read      = (i < 3);
            cur.dmem.write     = (i == 3);
            cur.dmem.addr      = {4'hD, 8'hDD, 11'(next_rand()), 6'(i), 1'(i)};
            cur.exp_dmem_rdata = '0;
            cur.exp_mem_stall  = 1'b1;
            push_row();
        end
        for (int i = 0; i < 2; i++) begin
            start_row();
            cur.dmem.read      = 1'b1;
            cur.dmem.addr      = {4'hE, 26'(next_rand())};
            cur.kb_ready       = (i == 1);
            cur.exp_dmem_rdata = {24'd0, cur.kb_keycode};
            cur.exp_kb_read    = 1'b1;
            cur.exp_mem_stall  = (i == 0);
            push_row();
        end
        start_row();
        cur.cache_stall   = 1'b1;
        cur.exp_mem_stall = 1'b1;
        push_row();
        start_row();
        push_row();
    endtask

    //////////////////////////////////////////////////
    // apply and check
    //////////////////////////////////////////////////

    task automatic drive_row(input row_t r);
        dmem         = r.dmem;
        instr_addr   = r.instr_addr;
        dc_rdata     = r.dc_rdata;
        ic_rdata     = r.ic_rdata;
        loader_rdata = r.loader_rdata;
        loader_instr = r.loader_instr;
        kb_ready     = r.kb_ready;
        kb_keycode   = r.kb_keycode;
        cache_stall  = r.cache_stall;
        trace_in     = r.trace_in;
    endtask

    task automatic check_row(input int n, input row_t r);
        check_value("dmem_rdata", n, 64'(dmem_rdata), 64'(r.exp_dmem_rdata));
        check_value("instr_rdata", n, 64'(instr_rdata), 64'(r.exp_instr_rdata));
        check_value("mem_stall", n, 64'(mem_stall), 64'(r.exp_mem_stall));
        check_value("dc_req", n, 64'(dc_req), 64'(r.exp_dc_req));
        check_value("loader_req", n, 64'(loader_req), 64'(r.exp_loader_req));
        check_value("loader_fetch", n, 64'(loader_fetch), 64'(r.exp_loader_fetch));
        check_value("kb_read", n, 64'(kb_read), 64'(r.exp_kb_read));
        check_value("vmem_wr.en", n, 64'(vmem_wr.en), 64'(r.exp_vmem_wr.en));
        if (r.exp_vmem_wr.en) begin
            check_value("vmem_wr.addr", n, 64'(vmem_wr.addr), 64'(r.exp_vmem_wr.addr));
            check_value("vmem_wr.char", n, 64'(vmem_wr.char), 64'(r.exp_vmem_wr.char));
        end
    endtask

    // one row per cycle, sampled mid cycle
    task automatic run_table();
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk_pipeline);
            #1;
            drive_row(rows[i]);
            @(negedge clk_pipeline);
            check_row(i, rows[i]);
        end
    endtask

    initial begin
        rst          = 1'b0;
        dmem         = '0;
        instr_addr   = '0;
        dc_rdata     = '0;
        ic_rdata     = '0;
        loader_rdata = '0;
        loader_instr = '0;
        kb_ready     = 1'b0;
        kb_keycode   = '0;
        cache_stall  = 1'b0;
        trace_in     = '0;
        lcg_state    = 32'd49;
        model_end    = 6'd0;

        add_region_reads();
        add_lane_writes();
        add_fetches();
        add_video_write(4'b1000, 2'd0);
        add_video_write(4'b0100, 2'd1);
        add_video_write(4'b0010, 2'd2);
        add_video_write(4'b1111, 2'd3);
        add_trace_run();
        add_stall_sources();
        add_trace_run();
        table_built = 1'b1;

        repeat (10) @(posedge clk_pipeline);
        #1;
        rst = 1'b1;
        run_table();
        $display("Test completed successfully");
        $finish;
    end

    initial begin
        wait (table_built);
        #((rows.size() + 200) * 8);
        $display("Timeout: the stimulus table did not finish in time");
        $display("Test failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

// File: list.f
rtl/mmio_pkg.sv
rtl/mmio_region_decode.sv
rtl/vmem_write_ctrl.sv
rtl/trace_queue.sv
rtl/mmio_read_mux.sv
rtl/cpu_mmio_bridge.sv
verification/cpu_mmio_bridge_tb.sv

// File: Makefile
# Verilator build and run of the MMIO bridge testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -f list.f --top-module cpu_mmio_bridge_tb \
		-Mdir obj_dir -o cpu_mmio_bridge_sim
	./obj_dir/cpu_mmio_bridge_sim

clean:
	rm -rf obj_dir
